//--- stopwatch.f
hdl/stopwatch_pkg.sv
hdl/button_sync.sv
hdl/centisecond_tick.sv
hdl/stopwatch_control.sv
hdl/bcd_time_counter.sv
hdl/seven_seg_decoder.sv
hdl/stopwatch.sv
sim/stopwatch_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the stopwatch testbench with Verilator and run it

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log

verilator --binary --assert -Wno-fatal --top-module stopwatch_tb \
  -f stopwatch.f -o stopwatch_sim > build.log 2>&1 \
  || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/stopwatch_sim > sim.log 2>&1
cat sim.log

grep -q "Test completed successfully" sim.log && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- sim/stopwatch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stopwatch_tb;

  localparam int TIMEOUT_CYCLES = 200;
  localparam int NUM_ROWS       = 6;
  localparam int BTN_START      = 0;
  localparam int BTN_SET        = 1;
  localparam int BTN_CHANGE     = 2;

  // digits 0 to 9, bit order g f e d c b a, active low
  localparam stopwatch_pkg::seg_t SEG_TABLE [10] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78, 7'h00, 7'h10
  };

  logic                clk100;
  logic                rstn;
  logic                start_stop;
  logic                set_btn;
  logic                change;
  stopwatch_pkg::seg_t hex0;
  stopwatch_pkg::seg_t hex1;
  stopwatch_pkg::seg_t hex2;
  stopwatch_pkg::seg_t hex3;

  logic [31:0] lfsr_state = 32'hf266;

  // one row per set-mode load, counts indexed from the hundredths digit
  string row_name   [NUM_ROWS];
  int    row_count  [NUM_ROWS][4];
  bit    row_start  [NUM_ROWS];
  int    row_expect [NUM_ROWS];

  stopwatch #(
    .TICKS_PER_CENTISECOND (4)
  ) stopwatch_inst (
    .clk100_i     (clk100),
    .rstn_i       (rstn),
    .start_stop_i (start_stop),
    .set_i        (set_btn),
    .change_i     (change),
    .hex0_o       (hex0),
    .hex1_o       (hex1),
    .hex2_o       (hex2),
    .hex3_o       (hex3)
  );

  initial
  begin
    clk100 = 1'b0;
    forever #10 clk100 = ~clk100;
  end

  // ##########################################################
  // random numbers
  // ##########################################################

  function automatic logic lfsr_step();
    logic out_bit;
    out_bit    = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (out_bit)
      lfsr_state = lfsr_state ^ 32'h8020_0003;
    return out_bit;
  endfunction

  function automatic int random_bits(input int width);
    int value;
    value = 0;
    for (int i = 0; i < width; i++)
      value = (value << 1) | int'(lfsr_step());
    return value;
  endfunction

  // ##########################################################
  // stimulus
  // ##########################################################

  task automatic drive_button(input int which, input logic level);
    @(posedge clk100);
    case (which)
      BTN_START: start_stop <= level;
      BTN_SET:   set_btn    <= level;
      default:   change     <= level;
    endcase
  endtask

  task automatic release_button(input int which);
    drive_button(which, 1'b1);
    repeat (7) @(posedge clk100);
  endtask

  task automatic press_button(input int which);
    drive_button(which, 1'b0);
    repeat (7) @(posedge clk100);
    release_button(which);
  endtask

  task automatic apply_reset();
    @(posedge clk100);
    rstn <= 1'b0;
    repeat (3) @(posedge clk100);
    rstn <= 1'b1;
  endtask

  task automatic load_digits(input int c0, input int c1, input int c2, input int c3,
                             input bit start_inside);
    int counts [4];
    counts = '{c0, c1, c2, c3};
    press_button(BTN_SET);
    // must not start the count while digits are edited
    if (start_inside)
      press_button(BTN_START);
    for (int d = 0; d < 4; d++)
    begin
      repeat (counts[d]) press_button(BTN_CHANGE);
      press_button(BTN_SET);
    end
  endtask

  // ##########################################################
  // checks
  // ##########################################################

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Test failed");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check_seg(input string name, input stopwatch_pkg::seg_t expected,
                           input stopwatch_pkg::seg_t actual);
    if (actual !== expected)
      abort_run($sformatf("CHECK FAILED %s expected %b actual %b", name, expected, actual));
  endtask

  task automatic check_time(input string name,
                            input stopwatch_pkg::seg_t e3, input stopwatch_pkg::seg_t e2,
                            input stopwatch_pkg::seg_t e1, input stopwatch_pkg::seg_t e0);
    check_seg({name, " hex3"}, e3, hex3);
    check_seg({name, " hex2"}, e2, hex2);
    check_seg({name, " hex1"}, e1, hex1);
    check_seg({name, " hex0"}, e0, hex0);
  endtask

  // pattern of one decimal position of a reading, 0 = hundredths
  function automatic stopwatch_pkg::seg_t expected_seg(input int value, input int pos);
    int div;
    div = 1;
    for (int i = 0; i < pos; i++)
      div = div * 10;
    return SEG_TABLE[(value / div) % 10];
  endfunction

  function automatic bit display_is(input int value);
    return (hex3 === expected_seg(value, 3)) && (hex2 === expected_seg(value, 2)) &&
           (hex1 === expected_seg(value, 1)) && (hex0 === expected_seg(value, 0));
  endfunction

  task automatic check_reading(input string name, input int value);
    @(negedge clk100);
    check_time(name, expected_seg(value, 3), expected_seg(value, 2),
               expected_seg(value, 1), expected_seg(value, 0));
  endtask

  function automatic int seg_digit(input stopwatch_pkg::seg_t seg);
    for (int d = 0; d < 10; d++)
      if (SEG_TABLE[d] === seg)
        return d;
    return -1;
  endfunction

  task automatic read_display(input string name, output int value);
    int d [4];
    @(negedge clk100);
    d = '{seg_digit(hex0), seg_digit(hex1), seg_digit(hex2), seg_digit(hex3)};
    if (d[0] < 0 || d[1] < 0 || d[2] < 0 || d[3] < 0)
      abort_run($sformatf("%s: a display shows a pattern that is no digit", name));
    value = d[3] * 1000 + d[2] * 100 + d[1] * 10 + d[0];
  endtask

  task automatic wait_display_change(input string name, input int old_value);
    int waited;
    waited = 0;
    @(negedge clk100);
    while (display_is(old_value) && waited < TIMEOUT_CYCLES)
    begin
      @(negedge clk100);
      waited++;
    end
    if (waited >= TIMEOUT_CYCLES)
      abort_run($sformatf("%s: display did not change in %0d cycles", name, TIMEOUT_CYCLES));
  endtask

  // each new reading is one hundredth on, 99.99 wraps to 00.00
  task automatic follow_count(input string name, input int start_value, input int steps);
    int value;
    value = start_value;
    for (int i = 0; i < steps; i++)
    begin
      wait_display_change(name, value);
      value = (value + 1) % 10000;
      check_reading(name, value);
    end
  endtask

  // ##########################################################
  // stimulus table
  // ##########################################################

  task automatic build_table();
    row_name[0]  = "zero_counts";
    row_count[0] = '{0, 0, 0, 0};
    row_start[0] = 1'b0;
    row_expect[0] = 0;
    row_name[1]  = "twelve_presses";
    row_count[1] = '{12, 3, 5, 1};
    row_start[1] = 1'b0;
    row_expect[1] = 1532;
    row_name[2]  = "start_in_set_mode";
    row_count[2] = '{4, 7, 0, 6};
    row_start[2] = 1'b1;
    row_expect[2] = 6074;
    for (int r = 3; r < NUM_ROWS; r++)
    begin
      row_name[r]   = $sformatf("random_row_%0d", r);
      row_expect[r] = 0;
      for (int d = 3; d >= 0; d--)
      begin
        row_count[r][d] = random_bits(4) % 10;
        row_expect[r]   = row_expect[r] * 10 + row_count[r][d] % 10;
      end
      row_start[r] = (random_bits(1) != 0);
    end
  endtask

  // ##########################################################
  // main sequence
  // ##########################################################

  initial
  begin
    int frozen;
    rstn       = 1'b0;
    start_stop = 1'b1;
    set_btn    = 1'b1;
    change     = 1'b1;
    build_table();
    apply_reset();

    check_reading("after_reset", 0);
    repeat (3) press_button(BTN_CHANGE);
    check_reading("change_outside_set", 0);

    for (int r = 0; r < NUM_ROWS; r++)
    begin
      apply_reset();
      load_digits(row_count[r][0], row_count[r][1], row_count[r][2], row_count[r][3],
                  row_start[r]);
      check_reading(row_name[r], row_expect[r]);
      repeat (40) @(posedge clk100);
      check_reading(row_name[r], row_expect[r]);
    end

    // set press while running is refused
    apply_reset();
    press_button(BTN_START);
    press_button(BTN_SET);
    press_button(BTN_CHANGE);
    press_button(BTN_START);
    read_display("set_while_running", frozen);
    repeat (3) press_button(BTN_CHANGE);
    check_reading("set_while_running", frozen);

    // carry from 09.99 into the seconds
    apply_reset();
    load_digits(9, 9, 9, 0, 1'b0);
    check_reading("load_09_99", 999);
    drive_button(BTN_START, 1'b0);
    follow_count("carry_to_10_00", 999, 5);
    release_button(BTN_START);

    // stop freezes, start resumes
    press_button(BTN_START);
    read_display("stop_freezes", frozen);
    repeat (100) check_reading("stop_freezes", frozen);
    drive_button(BTN_START, 1'b0);
    follow_count("restart_resumes", frozen, 4);
    release_button(BTN_START);

    apply_reset();
    load_digits(8, 9, 9, 9, 1'b0);
    check_reading("load_99_98", 9998);
    drive_button(BTN_START, 1'b0);
    follow_count("wrap_to_00_00", 9998, 3);
    release_button(BTN_START);

    $display("Test completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/stopwatch.sv
`timescale 1ns/1ps
`default_nettype none

module stopwatch #(
  parameter int unsigned TICKS_PER_CENTISECOND = stopwatch_pkg::TICKS_PER_CENTISECOND
) (
  input  logic                clk100_i,
  input  logic                rstn_i,
  input  logic                start_stop_i,
  input  logic                set_i,
  input  logic                change_i,
  output stopwatch_pkg::seg_t hex0_o,
  output stopwatch_pkg::seg_t hex1_o,
  output stopwatch_pkg::seg_t hex2_o,
  output stopwatch_pkg::seg_t hex3_o
);

  logic                      start_press;
  logic                      set_press;
  logic                      change_press;
  logic                      running;
  logic                      set_mode;
  logic                      incr;
  logic                      tick;
  stopwatch_pkg::digit_sel_t digit_sel;
  stopwatch_pkg::digit_t     hundredths;
  stopwatch_pkg::digit_t     tenths;
  stopwatch_pkg::digit_t     seconds;
  stopwatch_pkg::digit_t     ten_seconds;

  // ##########################################################
  // buttons
  // ##########################################################

  button_sync start_sync_inst (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .btn_n_i  (start_stop_i),
    .press_o  (start_press)
  );

  button_sync set_sync_inst (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .btn_n_i  (set_i),
    .press_o  (set_press)
  );

  button_sync change_sync_inst (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .btn_n_i  (change_i),
    .press_o  (change_press)
  );

  // ##########################################################
  // control, timebase and time digits
  // ##########################################################

  stopwatch_control control_inst (
    .clk100_i       (clk100_i),
    .rstn_i         (rstn_i),
    .start_press_i  (start_press),
    .set_press_i    (set_press),
    .change_press_i (change_press),
    .running_o      (running),
    .set_mode_o     (set_mode),
    .incr_o         (incr),
    .digit_sel_o    (digit_sel)
  );

  centisecond_tick #(
    .TICKS_PER_CENTISECOND (TICKS_PER_CENTISECOND)
  ) tick_inst (
    .clk100_i (clk100_i),
    .rstn_i   (rstn_i),
    .enable_i (running),
    .tick_o   (tick)
  );

  bcd_time_counter counter_inst (
    .clk100_i      (clk100_i),
    .rstn_i        (rstn_i),
    .tick_i        (tick),
    .set_mode_i    (set_mode),
    .incr_i        (incr),
    .digit_sel_i   (digit_sel),
    .hundredths_o  (hundredths),
    .tenths_o      (tenths),
    .seconds_o     (seconds),
    .ten_seconds_o (ten_seconds)
  );

  // displays, hex0 is the rightmost digit
  seven_seg_decoder hex0_dec_inst (.digit_i(hundredths),  .seg_o(hex0_o));
  seven_seg_decoder hex1_dec_inst (.digit_i(tenths),      .seg_o(hex1_o));
  seven_seg_decoder hex2_dec_inst (.digit_i(seconds),     .seg_o(hex2_o));
  seven_seg_decoder hex3_dec_inst (.digit_i(ten_seconds), .seg_o(hex3_o));

endmodule

`default_nettype wire

//--- hdl/seven_seg_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module seven_seg_decoder (
  input  stopwatch_pkg::digit_t digit_i,
  output stopwatch_pkg::seg_t   seg_o
);

  // bit order is g f e d c b a, a zero lights the segment
  always_comb
  begin
    case (digit_i)
      4'd0:    seg_o = 7'b100_0000;
      4'd1:    seg_o = 7'b111_1001;
      4'd2:    seg_o = 7'b010_0100;
      4'd3:    seg_o = 7'b011_0000;
      4'd4:    seg_o = 7'b001_1001;
      4'd5:    seg_o = 7'b001_0010;
      4'd6:    seg_o = 7'b000_0010;
      4'd7:    seg_o = 7'b111_1000;
      4'd8:    seg_o = 7'b000_0000;
      4'd9:    seg_o = 7'b001_0000;
      // all segments on
      default: seg_o = 7'b000_0000;
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/bcd_time_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_time_counter (
  input  logic                      clk100_i,
  input  logic                      rstn_i,
  input  logic                      tick_i,
  input  logic                      set_mode_i,
  input  logic                      incr_i,
  input  stopwatch_pkg::digit_sel_t digit_sel_i,
  output stopwatch_pkg::digit_t     hundredths_o,
  output stopwatch_pkg::digit_t     tenths_o,
  output stopwatch_pkg::digit_t     seconds_o,
  output stopwatch_pkg::digit_t     ten_seconds_o
);

  // index 0 is hundredths
  stopwatch_pkg::digit_t digits_q [stopwatch_pkg::NUM_DIGITS];
  stopwatch_pkg::digit_t digits_d [stopwatch_pkg::NUM_DIGITS];

  // carry into each digit
  logic [stopwatch_pkg::NUM_DIGITS-1:0] carry;

  function automatic stopwatch_pkg::digit_t next_digit(input stopwatch_pkg::digit_t d);
    if (d == stopwatch_pkg::DIGIT_MAX)
      return '0;
    else
      return d + 1;
  endfunction

  // ##########################################################
  // carry chain and set-mode increment
  // ##########################################################

  always_comb
  begin
    carry[0] = tick_i & ~set_mode_i;
    for (int i = 0; i < stopwatch_pkg::NUM_DIGITS - 1; i++)
    begin
      carry[i+1] = carry[i] & (digits_q[i] == stopwatch_pkg::DIGIT_MAX);
    end

    for (int i = 0; i < stopwatch_pkg::NUM_DIGITS; i++)
    begin
      digits_d[i] = digits_q[i];
      if (set_mode_i)
      begin
        // selected digit only, no carry
        if (incr_i && (digit_sel_i == stopwatch_pkg::digit_sel_t'(i)))
          digits_d[i] = next_digit(digits_q[i]);
      end
      else if (carry[i])
        digits_d[i] = next_digit(digits_q[i]);
    end
  end

  always_ff @(posedge clk100_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      for (int i = 0; i < stopwatch_pkg::NUM_DIGITS; i++)
      begin
        digits_q[i] <= '0;
      end
    end
    else
    begin
      for (int i = 0; i < stopwatch_pkg::NUM_DIGITS; i++)
      begin
        digits_q[i] <= digits_d[i];
      end
    end
  end

  assign hundredths_o  = digits_q[0];
  assign tenths_o      = digits_q[1];
  assign seconds_o     = digits_q[2];
  assign ten_seconds_o = digits_q[3];

  // ticks and set-mode edits both keep the digits decimal
  digits_decimal : assert property (
    @(posedge clk100_i) disable iff (!rstn_i)
    (hundredths_o  <= stopwatch_pkg::DIGIT_MAX) &&
    (tenths_o      <= stopwatch_pkg::DIGIT_MAX) &&
    (seconds_o     <= stopwatch_pkg::DIGIT_MAX) &&
    (ten_seconds_o <= stopwatch_pkg::DIGIT_MAX)
  )
    else $error("bcd_time_counter: digit above nine");

endmodule

`default_nettype wire

//--- hdl/stopwatch_control.sv
`timescale 1ns/1ps
`default_nettype none

module stopwatch_control (
  input  logic                      clk100_i,
  input  logic                      rstn_i,
  input  logic                      start_press_i,
  input  logic                      set_press_i,
  input  logic                      change_press_i,
  output logic                      running_o,
  output logic                      set_mode_o,
  output logic                      incr_o,
  output stopwatch_pkg::digit_sel_t digit_sel_o
);

  // ##########################################################
  // state
  // ##########################################################

  // setting_q low is idle, high is setting
  logic                      setting_q;
  logic                      setting_d;
  logic                      running_q;
  logic                      running_d;
  stopwatch_pkg::digit_sel_t digit_sel_q;
  stopwatch_pkg::digit_sel_t digit_sel_d;
  logic                      last_digit;

  assign last_digit =
    (digit_sel_q == stopwatch_pkg::digit_sel_t'(stopwatch_pkg::NUM_DIGITS - 1));

  // ##########################################################
  // next state
  // ##########################################################

  always_comb
  begin
    setting_d   = setting_q;
    running_d   = running_q;
    digit_sel_d = digit_sel_q;

    if (!setting_q)
    begin
      // start has priority over set in the same cycle
      if (start_press_i)
        running_d = ~running_q;
      else if (set_press_i && !running_q)
      begin
        setting_d   = 1'b1;
        digit_sel_d = '0;
      end
    end
    else if (set_press_i)
    begin
      if (last_digit)
      begin
        setting_d   = 1'b0;
        digit_sel_d = '0;
      end
      else
        digit_sel_d = digit_sel_q + 1;
    end
  end

  always_ff @(posedge clk100_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      setting_q   <= 1'b0;
      running_q   <= 1'b0;
      digit_sel_q <= '0;
    end
    else
    begin
      setting_q   <= setting_d;
      running_q   <= running_d;
      digit_sel_q <= digit_sel_d;
    end
  end

  assign running_o   = running_q;
  assign set_mode_o  = setting_q;
  assign digit_sel_o = digit_sel_q;

  // change presses only count in set mode
  assign incr_o = setting_q & change_press_i;

  // the divider never runs while digits are being edited
  run_set_exclusive : assert property (
    @(posedge clk100_i) disable iff (!rstn_i)
    !(running_o && set_mode_o)
  )
    else $error("stopwatch_control: running in set mode");

endmodule

`default_nettype wire

//--- hdl/centisecond_tick.sv
`timescale 1ns/1ps
`default_nettype none

module centisecond_tick #(
  parameter int unsigned TICKS_PER_CENTISECOND = stopwatch_pkg::TICKS_PER_CENTISECOND
) (
  input  logic clk100_i,
  input  logic rstn_i,
  input  logic enable_i,
  output logic tick_o
);

  localparam int unsigned LAST_CNT = TICKS_PER_CENTISECOND - 1;

  logic [stopwatch_pkg::TICK_CNT_W-1:0] cnt_q;
  logic                                 at_last;

  assign at_last = (cnt_q == LAST_CNT[stopwatch_pkg::TICK_CNT_W-1:0]);

  // holds while stopped so the current hundredth keeps its fraction
  always_ff @(posedge clk100_i or negedge rstn_i)
  begin
    if (!rstn_i)
      cnt_q <= '0;
    else if (enable_i)
    begin
      if (at_last)
        cnt_q <= '0;
      else
        cnt_q <= cnt_q + 1;
    end
  end

  assign tick_o = enable_i & at_last;

  // the count never runs past the terminal value
  count_in_range : assert property (
    @(posedge clk100_i) disable iff (!rstn_i)
    cnt_q <= LAST_CNT[stopwatch_pkg::TICK_CNT_W-1:0]
  )
    else $error("centisecond_tick: count past terminal value");

endmodule

`default_nettype wire

//--- hdl/button_sync.sv
`timescale 1ns/1ps
`default_nettype none

module button_sync (
  input  logic clk100_i,
  input  logic rstn_i,
  input  logic btn_n_i,
  output logic press_o
);

  // two synchronizer stages, then one history stage for the edge
  logic sync0_q;
  logic sync1_q;
  logic prev_q;

  always_ff @(posedge clk100_i or negedge rstn_i)
  begin
    if (!rstn_i)
    begin
      // released level
      sync0_q <= 1'b1;
      sync1_q <= 1'b1;
      prev_q  <= 1'b1;
    end
    else
    begin
      sync0_q <= btn_n_i;
      sync1_q <= sync0_q;
      prev_q  <= sync1_q;
    end
  end

  // falling edge of the synchronized level
  assign press_o = prev_q & ~sync1_q;

  // a held button gives only one pulse
  press_single_cycle : assert property (
    @(posedge clk100_i) disable iff (!rstn_i)
    press_o |=> !press_o
  )
    else $error("button_sync: press pulse longer than one cycle");

endmodule

`default_nettype wire

//--- hdl/stopwatch_pkg.sv
`default_nettype none

package stopwatch_pkg;

  // ##########################################################
  // display geometry
  // ##########################################################

  localparam int unsigned NUM_DIGITS = 4;
  localparam int unsigned DIGIT_W    = 4;

  // bit 0 is segment a, active low
  localparam int unsigned SEG_W      = 7;

  // ##########################################################
  // timebase
  // ##########################################################

  // 100 MHz clock into 100 Hz
  localparam int unsigned TICKS_PER_CENTISECOND = 1_000_000;
  localparam int unsigned TICK_CNT_W            = 20;

  // ##########################################################
  // shared types
  // ##########################################################

  typedef logic [DIGIT_W-1:0] digit_t;

  typedef logic [SEG_W-1:0] seg_t;

  // 0 = hundredths, 3 = tens of seconds
  typedef logic [$clog2(NUM_DIGITS)-1:0] digit_sel_t;

  // largest decimal digit value
  localparam digit_t DIGIT_MAX = digit_t'(9);

endpackage

`default_nettype wire
